// ==== rtl/hub75_cfg.svh ====
// geometry and refresh timing of the 16x8 panel, four row pairs deep
// COL_BITS and ROW_BITS must stay consistent with COLS and ROW_PAIRS
`ifndef HUB75_CFG_SVH
`define HUB75_CFG_SVH

// panel geometry
`define HUB75_COLS 16
`define HUB75_COL_BITS 4
`define HUB75_ROW_PAIRS 4
`define HUB75_ROW_BITS 2

// bitplane modulation
`define HUB75_PLANES 4
`define HUB75_BASE_TICKS 4   // plane p is lit for BASE_TICKS << p cycles

// read address to panel pins, store read plus output register
`define HUB75_PIPE_DEPTH 2

`endif

// ==== rtl/hub75_pixel_pkg.sv ====
// pixel, color and address types shared by the datapath
// rgb_t carries red in bit 2 and blue in bit 0
`default_nettype none
`include "hub75_cfg.svh"

package hub75_pixel_pkg;

    localparam int n_planes = `HUB75_PLANES;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] hi;   // first byte on the wire
        logic [7:0] lo;
    } byte_pair_t;

    // filled bytewise by the parser, read as color fields by the output stage
    typedef union packed {
        rgb565_t    rgb;
        byte_pair_t bytes;
    } pixel_word_u;

    typedef logic [`HUB75_COL_BITS-1:0] col_addr_t;
    typedef logic [`HUB75_ROW_BITS-1:0] row_addr_t;
    typedef logic [$clog2(`HUB75_PLANES)-1:0] plane_t;
    typedef logic [2:0] rgb_t;    // {red, green, blue}

    // row pair in the upper bits, column below
    typedef logic [`HUB75_ROW_BITS+`HUB75_COL_BITS-1:0] store_addr_t;

endpackage

`default_nettype wire

// ==== rtl/hub75_cmd_pkg.sv ====
// command byte encodings and parser states
// all arguments are single bytes and follow the opcode directly
`default_nettype none
`include "hub75_cfg.svh"

package hub75_cmd_pkg;

    localparam logic [7:0] op_pixel    = 8'h50;  // x, y, hi, lo
    localparam logic [7:0] op_channels = 8'h43;  // arg[2:0] is rgb enable
    localparam logic [7:0] op_planes   = 8'h42;  // arg[3:0] is plane enable

    typedef logic [`HUB75_PLANES-1:0] plane_mask_t;

    typedef enum logic [2:0] {
        idle,
        arg_x,
        arg_y,
        arg_hi,
        arg_lo,
        arg_mask
    } parse_state_t;

endpackage

`default_nettype wire

// ==== rtl/cmd_decode.sv ====
// byte stream parser, one byte per rx_valid strobe with no back-pressure
// unknown opcodes in idle are dropped and bits above the address range are ignored
`timescale 1ns/1ps
`default_nettype none

module cmd_decode (
    input  wire                              clk_root,
    input  wire                              arst_n,
    input  wire [7:0]                        rx_byte,
    input  wire                              rx_valid,
    output logic                             wr_en,
    output logic                             wr_half,
    output hub75_pixel_pkg::store_addr_t     wr_addr,
    output hub75_pixel_pkg::pixel_word_u     wr_data,
    output hub75_pixel_pkg::rgb_t            rgb_enable,
    output hub75_cmd_pkg::plane_mask_t       plane_enable
);

    localparam int col_w = $bits(hub75_pixel_pkg::col_addr_t);
    localparam int row_w = $bits(hub75_pixel_pkg::row_addr_t);

    hub75_cmd_pkg::parse_state_t state;
    logic mask_planes;   // arg_mask goes to plane_enable when set

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state        <= hub75_cmd_pkg::idle;
            mask_planes  <= 1'b0;
            wr_en        <= 1'b0;
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    hub75_cmd_pkg::idle: begin
                        case (rx_byte)
                            hub75_cmd_pkg::op_pixel: state <= hub75_cmd_pkg::arg_x;
                            hub75_cmd_pkg::op_channels: begin
                                state       <= hub75_cmd_pkg::arg_mask;
                                mask_planes <= 1'b0;
                            end
                            hub75_cmd_pkg::op_planes: begin
                                state       <= hub75_cmd_pkg::arg_mask;
                                mask_planes <= 1'b1;
                            end
                            default: state <= hub75_cmd_pkg::idle;
                        endcase
                    end
                    hub75_cmd_pkg::arg_x:  state <= hub75_cmd_pkg::arg_y;
                    hub75_cmd_pkg::arg_y:  state <= hub75_cmd_pkg::arg_hi;
                    hub75_cmd_pkg::arg_hi: state <= hub75_cmd_pkg::arg_lo;
                    hub75_cmd_pkg::arg_lo: begin
                        state <= hub75_cmd_pkg::idle;
                        wr_en <= 1'b1;   // word complete, store next cycle
                    end
                    hub75_cmd_pkg::arg_mask: begin
                        if (mask_planes) begin
                            plane_enable <= rx_byte[$bits(hub75_cmd_pkg::plane_mask_t)-1:0];
                        end else begin
                            rgb_enable <= rx_byte[2:0];
                        end
                        state <= hub75_cmd_pkg::idle;
                    end
                    default: state <= hub75_cmd_pkg::idle;
                endcase
            end
        end
    end

    // coordinates and data land straight in the write port registers
    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            case (state)
                hub75_cmd_pkg::arg_x: wr_addr[col_w-1:0] <= rx_byte[col_w-1:0];
                hub75_cmd_pkg::arg_y: begin
                    wr_addr[col_w +: row_w] <= rx_byte[row_w-1:0];
                    wr_half <= rx_byte[row_w];   // y 4..7 is the bottom half
                end
                hub75_cmd_pkg::arg_hi: wr_data.bytes.hi <= rx_byte;
                hub75_cmd_pkg::arg_lo: wr_data.bytes.lo <= rx_byte;
                default: ;
            endcase
        end
    end

    // a pixel takes five bytes, so two stores can never be back to back
    a_wr_single: assert property (@(posedge clk_root) disable iff (!arst_n)
        wr_en |=> !wr_en)
        else $error("wr_en high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== rtl/frame_store.sv ====
// two 64-word banks for the top and bottom half, contents undefined after power-up
// both banks are read at the same address with one cycle of latency
`timescale 1ns/1ps
`default_nettype none

module frame_store (
    input  wire                              clk_root,
    input  wire                              wr_en,
    input  wire                              wr_half,
    input  wire hub75_pixel_pkg::store_addr_t wr_addr,
    input  wire hub75_pixel_pkg::pixel_word_u wr_data,
    input  wire hub75_pixel_pkg::store_addr_t rd_addr,
    output hub75_pixel_pkg::pixel_word_u     rd_top,
    output hub75_pixel_pkg::pixel_word_u     rd_bottom
);

    localparam int depth = 2 ** $bits(hub75_pixel_pkg::store_addr_t);

    // bank 0 is rows 0..3, bank 1 is rows 4..7
    hub75_pixel_pkg::pixel_word_u mem [2][depth];

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_half][wr_addr] <= wr_data;
        end
    end

    // paired read port, same row pair and column from both halves
    always_ff @(posedge clk_root) begin
        rd_top    <= mem[0][rd_addr];
        rd_bottom <= mem[1][rd_addr];
    end

endmodule

`default_nettype wire

// ==== rtl/scan_timing.sv ====
// shift, latch, display sequencer for one plane at a time
// panel control lines are delayed by HUB75_PIPE_DEPTH to match the rgb pipeline
`timescale 1ns/1ps
`default_nettype none
`include "hub75_cfg.svh"

module scan_timing (
    input  wire                              clk_root,
    input  wire                              arst_n,
    output hub75_pixel_pkg::store_addr_t     rd_addr,
    output hub75_pixel_pkg::plane_t          plane,
    output logic                             clk_pixel,
    output logic                             row_latch,
    output logic                             oe_n,
    output hub75_pixel_pkg::row_addr_t       row_addr
);

    localparam logic [1:0] ph_shift = 2'd0;
    localparam logic [1:0] ph_latch = 2'd1;
    localparam logic [1:0] ph_disp  = 2'd2;

    // longest display period is the last plane
    localparam int disp_w = $clog2((`HUB75_BASE_TICKS << (`HUB75_PLANES - 1)) + 1);
    localparam int row_w = $bits(hub75_pixel_pkg::row_addr_t);
    localparam int ctl_w = 3 + row_w;
    localparam logic [ctl_w-1:0] ctl_reset = {3'b001, {row_w{1'b0}}};  // oe_n high

    logic [1:0]                     phase;
    hub75_pixel_pkg::col_addr_t     col;
    logic                           half;       // second cycle of a column
    hub75_pixel_pkg::plane_t        plane_cnt;
    hub75_pixel_pkg::row_addr_t     row;
    hub75_pixel_pkg::row_addr_t     row_shown;  // row on the panel since last latch
    hub75_pixel_pkg::row_addr_t     row_now;
    logic [disp_w-1:0]              disp_cnt;
    logic [ctl_w-1:0]               ctl_now;
    logic [ctl_w-1:0]               ctl_pipe [`HUB75_PIPE_DEPTH];

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            phase     <= ph_shift;
            col       <= '0;
            half      <= 1'b0;
            plane_cnt <= '0;
            row       <= '0;
            row_shown <= '0;
            disp_cnt  <= '0;
        end else begin
            case (phase)
                ph_shift: begin
                    half <= ~half;
                    if (half) begin
                        if (col == hub75_pixel_pkg::col_addr_t'(`HUB75_COLS - 1)) begin
                            col   <= '0;
                            phase <= ph_latch;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                ph_latch: begin
                    row_shown <= row;
                    disp_cnt  <= (disp_w'(`HUB75_BASE_TICKS) << plane_cnt) - 1'b1;
                    phase     <= ph_disp;
                end
                ph_disp: begin
                    if (disp_cnt == '0) begin
                        phase <= ph_shift;
                        if (plane_cnt == hub75_pixel_pkg::plane_t'(`HUB75_PLANES - 1)) begin
                            plane_cnt <= '0;
                            row <= (row == row_w'(`HUB75_ROW_PAIRS - 1)) ? '0 : row + 1'b1;
                        end else begin
                            plane_cnt <= plane_cnt + 1'b1;
                        end
                    end else begin
                        disp_cnt <= disp_cnt - 1'b1;
                    end
                end
                default: phase <= ph_shift;
            endcase
        end
    end

    assign rd_addr = {row, col};
    assign row_now = (phase == ph_latch) ? row : row_shown;  // switch with the latch
    assign ctl_now = {phase == ph_shift && half, phase == ph_latch, phase != ph_disp, row_now};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `HUB75_PIPE_DEPTH; i++) begin
                ctl_pipe[i] <= ctl_reset;
            end
            plane <= '0;
        end else begin
            ctl_pipe[0] <= ctl_now;
            for (int i = 1; i < `HUB75_PIPE_DEPTH; i++) begin
                ctl_pipe[i] <= ctl_pipe[i-1];
            end
            plane <= plane_cnt;   // lines up with the store read data
        end
    end

    assign {clk_pixel, row_latch, oe_n, row_addr} = ctl_pipe[`HUB75_PIPE_DEPTH-1];

    // the panel is dark while latching and lights up right after
    a_latch_dark: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |-> oe_n ##1 !oe_n)
        else $error("row_latch not framed by display off then on");

endmodule

`default_nettype wire

// ==== rtl/bitplane_out.sv ====
// picks the bit of the current plane from each channel, top bits of each field
// masks apply one cycle after they change and outputs are registered
`timescale 1ns/1ps
`default_nettype none

module bitplane_out (
    input  wire                              clk_root,
    input  wire                              arst_n,
    input  wire hub75_pixel_pkg::pixel_word_u rd_top,
    input  wire hub75_pixel_pkg::pixel_word_u rd_bottom,
    input  wire hub75_pixel_pkg::plane_t      plane,
    input  wire hub75_pixel_pkg::rgb_t        rgb_enable,
    input  wire hub75_cmd_pkg::plane_mask_t   plane_enable,
    output hub75_pixel_pkg::rgb_t            rgb_top,
    output hub75_pixel_pkg::rgb_t            rgb_bottom
);

    // bit (width - planes + p) of each field, so red[1+p], green[2+p], blue[1+p]
    function automatic hub75_pixel_pkg::rgb_t pick_plane(
        input hub75_pixel_pkg::pixel_word_u px,
        input hub75_pixel_pkg::plane_t      p
    );
        hub75_pixel_pkg::rgb565_t c;
        c = px.rgb;
        return {c.red[$bits(c.red) - hub75_pixel_pkg::n_planes + int'(p)],
                c.green[$bits(c.green) - hub75_pixel_pkg::n_planes + int'(p)],
                c.blue[$bits(c.blue) - hub75_pixel_pkg::n_planes + int'(p)]};
    endfunction

    logic plane_on;

    assign plane_on = plane_enable[plane];

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            rgb_top    <= plane_on ? (pick_plane(rd_top, plane) & rgb_enable) : '0;
            rgb_bottom <= plane_on ? (pick_plane(rd_bottom, plane) & rgb_enable) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hub75_top.sv ====
// HUB75 driver for a 16x8 panel, 1/4 scan, four bitplanes per channel
// bytes come in already framed and are never stalled, everything runs on clk_root
`timescale 1ns/1ps
`default_nettype none

module hub75_top (
    input  wire                              clk_root,
    input  wire                              arst_n,
    input  wire [7:0]                        rx_byte,
    input  wire                              rx_valid,
    output hub75_pixel_pkg::rgb_t            rgb_top,
    output hub75_pixel_pkg::rgb_t            rgb_bottom,
    output logic                             clk_pixel,
    output logic                             row_latch,
    output logic                             oe_n,
    output hub75_pixel_pkg::row_addr_t       row_addr
);

    // parser to store and output stage
    logic                           wr_en;
    logic                           wr_half;
    hub75_pixel_pkg::store_addr_t   wr_addr;
    hub75_pixel_pkg::pixel_word_u   wr_data;
    hub75_pixel_pkg::rgb_t          rgb_enable;
    hub75_cmd_pkg::plane_mask_t     plane_enable;

    // scan side
    hub75_pixel_pkg::store_addr_t   rd_addr;
    hub75_pixel_pkg::pixel_word_u   rd_top;
    hub75_pixel_pkg::pixel_word_u   rd_bottom;
    hub75_pixel_pkg::plane_t        plane;

    cmd_decode u_cmd_decode (
        .clk_root     (clk_root),
        .arst_n       (arst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .wr_en        (wr_en),
        .wr_half      (wr_half),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable)
    );

    frame_store u_frame_store (
        .clk_root  (clk_root),
        .wr_en     (wr_en),
        .wr_half   (wr_half),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_top    (rd_top),
        .rd_bottom (rd_bottom)
    );

    scan_timing u_scan_timing (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .rd_addr   (rd_addr),
        .plane     (plane),
        .clk_pixel (clk_pixel),
        .row_latch (row_latch),
        .oe_n      (oe_n),
        .row_addr  (row_addr)
    );

    bitplane_out u_bitplane_out (
        .clk_root     (clk_root),
        .arst_n       (arst_n),
        .rd_top       (rd_top),
        .rd_bottom    (rd_bottom),
        .plane        (plane),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .rgb_top      (rgb_top),
        .rgb_bottom   (rgb_bottom)
    );

endmodule

`default_nettype wire

// ==== sim/tb_hub75.sv ====
// frame store contents are undefined after reset until all 128 pixels are written
// each table case is checked over one full frame that starts after its commands
`timescale 1ns/1ps
`default_nettype none
`include "hub75_cfg.svh"

module tb_hub75;

    localparam int n_cases  = 7;
    localparam int max_over = 4;
    localparam int frame_cycles = `HUB75_ROW_PAIRS * (`HUB75_PLANES * (2 * `HUB75_COLS + 1)
                                  + `HUB75_BASE_TICKS * ((1 << `HUB75_PLANES) - 1));
    // two cycles per byte, full load plus the commands of every case
    localparam int write_cycles = 2 * (128 * 5 + n_cases * (1 + 4 + 5 * max_over)) + 64;
    // a case waits for the end of the running frame, then one full frame
    localparam int cycle_limit  = (2 * n_cases + 2) * frame_cycles + write_cycles;

    typedef struct packed {
        logic [2:0] rgb_en;
        logic [3:0] plane_en;
        logic       has_stray;
        logic [7:0] stray;
        logic [2:0] n_over;   // pixels rewritten in this case
    } case_t;

    logic                       clk_root;
    logic                       arst_n;
    logic [7:0]                 rx_byte;
    logic                       rx_valid;
    hub75_pixel_pkg::rgb_t      rgb_top;
    hub75_pixel_pkg::rgb_t      rgb_bottom;
    logic                       clk_pixel;
    logic                       row_latch;
    logic                       oe_n;
    hub75_pixel_pkg::row_addr_t row_addr;

    case_t       cases [n_cases];
    logic [15:0] shadow [8][16];   // [y][x], last value written
    logic [31:0] rng;
    logic [2:0]  exp_rgb_en;
    logic [3:0]  exp_plane_en;
    logic [2:0]  cap_top [16];
    logic [2:0]  cap_bot [16];
    int errors;
    int n_checks;
    int cycles = 0;
    int col_idx;
    int seq_row;
    int seq_plane;
    int last_plane;
    int disp_run;
    int frames_done;
    bit arm_req;
    bit checking;
    bit seen_latch;
    bit disp_closed;   // display period since the last latch was measured

    hub75_top u_dut (
        .clk_root   (clk_root),
        .arst_n     (arst_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n),
        .row_addr   (row_addr)
    );

    initial begin
        clk_root = 1'b0;
        forever #5 clk_root = ~clk_root;
    end

    always @(posedge clk_root) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: test did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // word is r[15:11] g[10:5] b[4:0]; plane p shows red[1+p], green[2+p], blue[1+p]
    function automatic logic [2:0] expect_bits(input logic [15:0] w, input int p,
                                               input logic [2:0] en_rgb,
                                               input logic [3:0] en_pl);
        logic [2:0] b;
        b = {w[12 + p], w[7 + p], w[1 + p]};
        if (!en_pl[p]) b = 3'b000;
        return b & en_rgb;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk_root);
        rx_byte  = b;
        rx_valid = 1'b1;
        @(negedge clk_root);
        rx_valid = 1'b0;
    endtask

    task automatic write_pixel(input logic [3:0] x, input logic [2:0] y, input logic [15:0] w);
        send_byte(hub75_cmd_pkg::op_pixel);
        send_byte({4'h0, x});
        send_byte({5'h00, y});
        send_byte(w[15:8]);   // high byte first
        send_byte(w[7:0]);
        shadow[y][x] = w;
    endtask

    task automatic load_table();
        cases[0] = '{3'b111, 4'b1111, 1'b0, 8'h00, 3'd0};   // plain frame
        cases[1] = '{3'b101, 4'b1111, 1'b1, 8'hA5, 3'd2};   // green off
        cases[2] = '{3'b111, 4'b0101, 1'b1, 8'h00, 3'd1};
        cases[3] = '{3'b010, 4'b1110, 1'b1, 8'h51, 3'd3};
        cases[4] = '{3'b000, 4'b1111, 1'b0, 8'h00, 3'd0};   // everything dark
        cases[5] = '{3'b111, 4'b0000, 1'b1, 8'hFF, 3'd1};
        cases[6] = '{3'b111, 4'b1111, 1'b1, 8'h44, 3'd4};   // next to the opcodes
    endtask

    task automatic compare_latch();
        logic [2:0] exp_t;
        logic [2:0] exp_b;
        if (seen_latch && !disp_closed) begin
            errors++;
            $display("no display period seen after the latch of plane %0d", last_plane);
        end
        if (col_idx != `HUB75_COLS) begin
            errors++;
            $display("Fail t=%0t clk_pixel pulses expected %0d actual %0d",
                     $time, `HUB75_COLS, col_idx);
        end
        if (row_addr !== hub75_pixel_pkg::row_addr_t'(seq_row)) begin
            errors++;
            $display("Fail t=%0t row_addr expected %0d actual %0d", $time, seq_row, row_addr);
        end
        if (checking) begin
            for (int c = 0; c < `HUB75_COLS; c++) begin
                exp_t = expect_bits(shadow[seq_row][c], seq_plane, exp_rgb_en, exp_plane_en);
                exp_b = expect_bits(shadow[seq_row + `HUB75_ROW_PAIRS][c], seq_plane,
                                    exp_rgb_en, exp_plane_en);
                n_checks += 2;
                if (cap_top[c] !== exp_t) begin
                    errors++;
                    $display("Fail t=%0t rgb_top row %0d plane %0d col %0d expected %b actual %b",
                             $time, seq_row, seq_plane, c, exp_t, cap_top[c]);
                end
                if (cap_bot[c] !== exp_b) begin
                    errors++;
                    $display("Fail t=%0t rgb_bottom row %0d plane %0d col %0d expected %b actual %b",
                             $time, seq_row, seq_plane, c, exp_b, cap_bot[c]);
                end
            end
        end
        // last latch of a frame closes a check or opens one
        if (seq_row == `HUB75_ROW_PAIRS - 1 && seq_plane == `HUB75_PLANES - 1) begin
            if (checking) begin
                checking = 1'b0;
                frames_done++;
            end else if (arm_req) begin
                checking = 1'b1;
                arm_req  = 1'b0;
            end
        end
        last_plane  = seq_plane;
        disp_run    = 0;
        disp_closed = 1'b0;
        col_idx     = 0;
        seen_latch  = 1'b1;
        seq_plane   = (seq_plane + 1) % `HUB75_PLANES;
        if (seq_plane == 0) seq_row = (seq_row + 1) % `HUB75_ROW_PAIRS;
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk_root) begin
        if (!arst_n) begin
            if (oe_n !== 1'b1) begin
                errors++;
                $display("Fail t=%0t oe_n in reset expected 1 actual %b", $time, oe_n);
            end
            if (row_latch !== 1'b0) begin
                errors++;
                $display("Fail t=%0t row_latch in reset expected 0 actual %b", $time, row_latch);
            end
            if (clk_pixel !== 1'b0) begin
                errors++;
                $display("Fail t=%0t clk_pixel in reset expected 0 actual %b", $time, clk_pixel);
            end
            if (row_addr !== 2'd0) begin
                errors++;
                $display("Fail t=%0t row_addr in reset expected 0 actual %0d", $time, row_addr);
            end
        end else begin
            if (!seen_latch && (oe_n !== 1'b1 || row_addr !== 2'd0)) begin
                errors++;
                $display("Fail t=%0t oe_n/row_addr before first latch expected 1/0 actual %b/%0d",
                         $time, oe_n, row_addr);
            end
            if (clk_pixel === 1'b1 && oe_n !== 1'b1) begin
                errors++;
                $display("Fail t=%0t oe_n during shift expected 1 actual %b", $time, oe_n);
            end
            if (clk_pixel === 1'b1) begin
                if (col_idx < `HUB75_COLS) begin
                    cap_top[col_idx] = rgb_top;
                    cap_bot[col_idx] = rgb_bottom;
                end
                col_idx++;
            end
            if (oe_n === 1'b0) begin
                disp_run++;
            end else if (disp_run != 0) begin
                if (disp_run != (`HUB75_BASE_TICKS << last_plane)) begin
                    errors++;
                    $display("Fail t=%0t oe_n low cycles plane %0d expected %0d actual %0d",
                             $time, last_plane, `HUB75_BASE_TICKS << last_plane, disp_run);
                end
                disp_run    = 0;
                disp_closed = 1'b1;
            end
            if (row_latch === 1'b1) compare_latch();
        end
    end

    initial begin
        int target;
        logic [3:0] x;
        logic [2:0] y;
        rx_byte      = 8'h00;
        rx_valid     = 1'b0;
        arst_n       = 1'b0;
        rng          = 32'h54ef_28a0;
        exp_rgb_en   = 3'b111;
        exp_plane_en = 4'b1111;
        errors       = 0;
        n_checks     = 0;
        col_idx      = 0;
        seq_row      = 0;
        seq_plane    = 0;
        last_plane   = 0;
        disp_run     = 0;
        frames_done  = 0;
        arm_req      = 1'b0;
        checking     = 1'b0;
        seen_latch   = 1'b0;
        disp_closed  = 1'b0;
        load_table();
        repeat (4) @(posedge clk_root);
        @(negedge clk_root);
        arst_n = 1'b1;

        for (int yy = 0; yy < 8; yy++) begin
            for (int xx = 0; xx < `HUB75_COLS; xx++) begin
                rng = lcg_next(rng);
                write_pixel(4'(xx), 3'(yy), rng[31:16]);
            end
        end

        for (int i = 0; i < n_cases; i++) begin
            if (cases[i].has_stray) send_byte(cases[i].stray);   // idle parser drops it
            send_byte(hub75_cmd_pkg::op_channels);
            send_byte({5'h00, cases[i].rgb_en});
            send_byte(hub75_cmd_pkg::op_planes);
            send_byte({4'h0, cases[i].plane_en});
            for (int k = 0; k < int'(cases[i].n_over); k++) begin
                rng = lcg_next(rng);
                x   = rng[27:24];
                y   = rng[30:28];
                rng = lcg_next(rng);
                write_pixel(x, y, rng[31:16]);
            end
            @(posedge clk_root);
            exp_rgb_en   = cases[i].rgb_en;
            exp_plane_en = cases[i].plane_en;
            target       = frames_done + 1;
            arm_req      = 1'b1;
            while (frames_done < target) @(posedge clk_root);
        end

        $display("errors=%0d checks=%0d frames=%0d", errors, n_checks, frames_done);
        if (errors == 0 && n_checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hub75_lite.f ====
+incdir+rtl
rtl/hub75_pixel_pkg.sv
rtl/hub75_cmd_pkg.sv
rtl/cmd_decode.sv
rtl/frame_store.sv
rtl/scan_timing.sv
rtl/bitplane_out.sv
rtl/hub75_top.sv
sim/tb_hub75.sv

// ==== Makefile ====
# Verilator build and run of the hub75_lite testbench
VERILATOR ?= verilator
TOP       ?= tb_hub75
FLIST     ?= hub75_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS) rtl/hub75_cfg.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# the log decides the result, not the exit code of the binary
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^All checks passed$$' $(LOG) && echo "PASS" || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
